/* hdl/mmc5_pkg.sv */
// Shared MMC5 constants, register addresses and banking mode types, imported by the RTL and testbench
package mmc5_pkg;

	// Bus and output address widths
	localparam int CPU_AW     = 16;
	localparam int PRG_OUT_AW = 22;
	localparam int PPU_AW     = 14;
	localparam int CHR_OUT_AW = 22;

	// Register field widths
	localparam int PRG_BANK_W    = 8;
	localparam int CHR_BANK_W    = 8;
	localparam int RAM_BANK_W    = 3;
	localparam int MIRROR_W      = 8; // Two bits per nametable quadrant
	localparam int SCANLINE_W    = 8;
	localparam int NUM_CHR_BANKS = 8;

	// CPU register map
	localparam logic [CPU_AW-1:0] REG_PRG_MODE     = 16'h5100;
	localparam logic [CPU_AW-1:0] REG_CHR_MODE     = 16'h5101;
	localparam logic [CPU_AW-1:0] REG_PROT1        = 16'h5102;
	localparam logic [CPU_AW-1:0] REG_PROT2        = 16'h5103;
	localparam logic [CPU_AW-1:0] REG_MIRROR       = 16'h5105;
	localparam logic [CPU_AW-1:0] REG_PRG_RAM_BANK = 16'h5113;
	localparam logic [CPU_AW-1:0] REG_PRG_BANK0    = 16'h5114;
	localparam logic [CPU_AW-1:0] REG_PRG_BANK1    = 16'h5115;
	localparam logic [CPU_AW-1:0] REG_PRG_BANK2    = 16'h5116;
	localparam logic [CPU_AW-1:0] REG_PRG_BANK3    = 16'h5117;
	localparam logic [CPU_AW-1:0] REG_CHR_BANK0    = 16'h5120; // Banks 1 to 7 follow
	localparam logic [CPU_AW-1:0] REG_IRQ_LINE     = 16'h5203;
	localparam logic [CPU_AW-1:0] REG_IRQ_STATUS   = 16'h5204;
	localparam logic [CPU_AW-1:0] REG_MUL_A        = 16'h5205;
	localparam logic [CPU_AW-1:0] REG_MUL_B        = 16'h5206;

	// Both keys must be written before PRG RAM accepts writes
	localparam logic [1:0] PROT1_KEY = 2'b10;
	localparam logic [1:0] PROT2_KEY = 2'b01;

	// Scanline detection
	localparam logic [SCANLINE_W-1:0] LAST_SCANLINE = 8'd239;
	localparam logic [1:0] NT_REPEAT     = 2'd3; // Identical NT reads before the frame is armed
	localparam logic [1:0] IDLE_CE_LIMIT = 2'd3; // Read-free CPU cycles before leaving the frame
	localparam logic [CPU_AW-1:0] NMI_VECTOR = 16'hFFFA;

	// PRG space
	localparam logic [CPU_AW-1:0] PRG_RAM_BASE = 16'h6000;
	localparam logic [5:0] PRG_RAM_PAGE = 6'b111100;

	typedef enum logic [1:0] {
		PRG_32K,
		PRG_16K,
		PRG_16K_8K,
		PRG_8K
	} prg_mode_e;

	typedef enum logic [1:0] {
		CHR_8K,
		CHR_4K,
		CHR_2K,
		CHR_1K
	} chr_mode_e;

endpackage

/* hdl/mmc5_regs.sv */
// MMC5 CPU register file, holds banking, mirroring, IRQ and multiplier state and returns read data
`timescale 1ns/1ps

module mmc5_regs (
	input  logic                              clk,
	input  logic                              rst_i,
	input  logic                              ce_i,
	input  logic [mmc5_pkg::CPU_AW-1:0]       prg_addr_i,
	input  logic [7:0]                        prg_data_i,
	input  logic                              prg_write_i,
	input  logic                              prg_read_i,
	input  logic                              in_frame_i,
	input  logic                              irq_pending_i,
	output logic [7:0]                        prg_dout_o,
	output logic                              prg_dout_valid_o,
	output mmc5_pkg::prg_mode_e               prg_mode_o,
	output logic [mmc5_pkg::PRG_BANK_W-1:0]   prg_bank0_o,
	output logic [mmc5_pkg::PRG_BANK_W-1:0]   prg_bank1_o,
	output logic [mmc5_pkg::PRG_BANK_W-1:0]   prg_bank2_o,
	output logic [mmc5_pkg::PRG_BANK_W-1:0]   prg_bank3_o,
	output logic [mmc5_pkg::RAM_BANK_W-1:0]   ram_bank_o,
	output logic                              ram_we_o,
	output mmc5_pkg::chr_mode_e               chr_mode_o,
	output logic [mmc5_pkg::CHR_BANK_W-1:0]   chr_bank0_o,
	output logic [mmc5_pkg::CHR_BANK_W-1:0]   chr_bank1_o,
	output logic [mmc5_pkg::CHR_BANK_W-1:0]   chr_bank2_o,
	output logic [mmc5_pkg::CHR_BANK_W-1:0]   chr_bank3_o,
	output logic [mmc5_pkg::CHR_BANK_W-1:0]   chr_bank4_o,
	output logic [mmc5_pkg::CHR_BANK_W-1:0]   chr_bank5_o,
	output logic [mmc5_pkg::CHR_BANK_W-1:0]   chr_bank6_o,
	output logic [mmc5_pkg::CHR_BANK_W-1:0]   chr_bank7_o,
	output logic [mmc5_pkg::MIRROR_W-1:0]     mirroring_o,
	output logic [mmc5_pkg::SCANLINE_W-1:0]   irq_line_o,
	output logic                              irq_status_rd_o,
	output logic                              irq_o
);
	import mmc5_pkg::*;

	logic                  prot1;
	logic                  prot2;
	logic                  irq_enable;
	logic [7:0]            mul_a;
	logic [7:0]            mul_b;
	logic [15:0]           product;
	logic [CHR_BANK_W-1:0] chr_bank [NUM_CHR_BANKS];
	logic                  wr_en;

	assign wr_en    = ce_i && prg_write_i;
	assign ram_we_o = prot1 && prot2; // Unlocked only while both keys hold
	assign product  = mul_a * mul_b;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			prg_mode_o  <= PRG_8K;
			chr_mode_o  <= CHR_8K;
			prot1       <= 1'b0;
			prot2       <= 1'b0;
			mirroring_o <= '0;
			ram_bank_o  <= '0;
			prg_bank0_o <= '0;
			prg_bank1_o <= '0;
			prg_bank2_o <= '0;
			prg_bank3_o <= 8'h7F; // Last ROM page holds the reset vector
			irq_line_o  <= '0;
			irq_enable  <= 1'b0;
			mul_a       <= '0;
			mul_b       <= '0;
			for (int i = 0; i < NUM_CHR_BANKS; i++) begin
				chr_bank[i] <= '0;
			end
		end else if (wr_en) begin
			case (prg_addr_i)
				REG_PRG_MODE:     prg_mode_o <= prg_mode_e'(prg_data_i[1:0]);
				REG_CHR_MODE:     chr_mode_o <= chr_mode_e'(prg_data_i[1:0]);
				REG_PROT1:        prot1 <= (prg_data_i[1:0] == PROT1_KEY);
				REG_PROT2:        prot2 <= (prg_data_i[1:0] == PROT2_KEY);
				REG_MIRROR:       mirroring_o <= prg_data_i;
				REG_PRG_RAM_BANK: ram_bank_o <= prg_data_i[RAM_BANK_W-1:0];
				REG_PRG_BANK0:    prg_bank0_o <= prg_data_i;
				REG_PRG_BANK1:    prg_bank1_o <= prg_data_i;
				REG_PRG_BANK2:    prg_bank2_o <= prg_data_i;
				REG_PRG_BANK3:    prg_bank3_o <= prg_data_i;
				REG_IRQ_LINE:     irq_line_o <= prg_data_i;
				REG_IRQ_STATUS:   irq_enable <= prg_data_i[7];
				REG_MUL_A:        mul_a <= prg_data_i;
				REG_MUL_B:        mul_b <= prg_data_i;
				default: begin
				end
			endcase
			// $5120-$5127, one bank per address
			if (prg_addr_i[CPU_AW-1:3] == REG_CHR_BANK0[CPU_AW-1:3]) begin
				chr_bank[prg_addr_i[2:0]] <= prg_data_i;
			end
		end
	end

	assign chr_bank0_o = chr_bank[0];
	assign chr_bank1_o = chr_bank[1];
	assign chr_bank2_o = chr_bank[2];
	assign chr_bank3_o = chr_bank[3];
	assign chr_bank4_o = chr_bank[4];
	assign chr_bank5_o = chr_bank[5];
	assign chr_bank6_o = chr_bank[6];
	assign chr_bank7_o = chr_bank[7];

	// Status read strobe and IRQ output
	always_ff @(posedge clk) begin
		if (rst_i) begin
			irq_status_rd_o <= 1'b0;
			irq_o           <= 1'b0;
		end else begin
			irq_status_rd_o <= ce_i && prg_read_i && (prg_addr_i == REG_IRQ_STATUS);
			irq_o           <= irq_pending_i && irq_enable;
		end
	end

	always_comb begin
		prg_dout_valid_o = 1'b1;
		case (prg_addr_i)
			REG_IRQ_STATUS: prg_dout_o = {irq_pending_i, in_frame_i, 6'b111111};
			REG_MUL_A:      prg_dout_o = product[7:0];
			REG_MUL_B:      prg_dout_o = product[15:8];
			default: begin
				prg_dout_o       = 8'hFF; // Open bus
				prg_dout_valid_o = 1'b0;
			end
		endcase
	end

endmodule

/* hdl/mmc5_prg_map.sv */
// MMC5 PRG address translation, maps CPU addresses to 8 kB ROM or RAM pages and gates access
`timescale 1ns/1ps

module mmc5_prg_map (
	input  logic [mmc5_pkg::CPU_AW-1:0]     prg_addr_i,
	input  logic                            prg_write_i,
	input  mmc5_pkg::prg_mode_e             prg_mode_i,
	input  logic [mmc5_pkg::PRG_BANK_W-1:0] prg_bank0_i,
	input  logic [mmc5_pkg::PRG_BANK_W-1:0] prg_bank1_i,
	input  logic [mmc5_pkg::PRG_BANK_W-1:0] prg_bank2_i,
	input  logic [mmc5_pkg::PRG_BANK_W-1:0] prg_bank3_i,
	input  logic [mmc5_pkg::RAM_BANK_W-1:0] ram_bank_i,
	input  logic                            ram_we_i,
	output logic [mmc5_pkg::PRG_OUT_AW-1:0] prg_aout_o,
	output logic                            prg_allow_o
);
	import mmc5_pkg::*;

	logic [7:0] prg_sel; // Bit 7 set selects ROM
	logic       is_rom;

	always_comb begin
		if (!prg_addr_i[15]) begin
			prg_sel = {5'b00000, ram_bank_i}; // $6000-$7FFF in every mode
		end else begin
			case (prg_mode_i)
				PRG_32K: prg_sel = {1'b1, prg_bank3_i[6:2], prg_addr_i[14:13]};
				PRG_16K: begin
					if (prg_addr_i[14])
						prg_sel = {1'b1, prg_bank3_i[6:1], prg_addr_i[13]};
					else
						prg_sel = {prg_bank1_i[7:1], prg_addr_i[13]};
				end
				PRG_16K_8K: begin
					if (!prg_addr_i[14])
						prg_sel = {prg_bank1_i[7:1], prg_addr_i[13]};
					else if (!prg_addr_i[13])
						prg_sel = prg_bank2_i;
					else
						prg_sel = {1'b1, prg_bank3_i[6:0]};
				end
				default: begin
					case (prg_addr_i[14:13])
						2'd0:    prg_sel = prg_bank0_i;
						2'd1:    prg_sel = prg_bank1_i;
						2'd2:    prg_sel = prg_bank2_i;
						default: prg_sel = {1'b1, prg_bank3_i[6:0]};
					endcase
				end
			endcase
		end
	end

	assign is_rom = prg_sel[7];

	// RAM pages sit at the top of the PRG output space
	assign prg_aout_o = is_rom ? {2'b00, prg_sel[6:0], prg_addr_i[12:0]}
	                           : {PRG_RAM_PAGE, prg_sel[2:0], prg_addr_i[12:0]};

	assign prg_allow_o = (prg_addr_i >= PRG_RAM_BASE) && (!prg_write_i || (!is_rom && ram_we_i));

endmodule

/* hdl/mmc5_chr_map.sv */
// MMC5 CHR bank selection and nametable mirroring, maps PPU addresses to CHR ROM and console VRAM
`timescale 1ns/1ps

module mmc5_chr_map (
	input  logic [mmc5_pkg::PPU_AW-1:0]     chr_addr_i,
	input  mmc5_pkg::chr_mode_e             chr_mode_i,
	input  logic [mmc5_pkg::CHR_BANK_W-1:0] chr_bank0_i,
	input  logic [mmc5_pkg::CHR_BANK_W-1:0] chr_bank1_i,
	input  logic [mmc5_pkg::CHR_BANK_W-1:0] chr_bank2_i,
	input  logic [mmc5_pkg::CHR_BANK_W-1:0] chr_bank3_i,
	input  logic [mmc5_pkg::CHR_BANK_W-1:0] chr_bank4_i,
	input  logic [mmc5_pkg::CHR_BANK_W-1:0] chr_bank5_i,
	input  logic [mmc5_pkg::CHR_BANK_W-1:0] chr_bank6_i,
	input  logic [mmc5_pkg::CHR_BANK_W-1:0] chr_bank7_i,
	input  logic [mmc5_pkg::MIRROR_W-1:0]   mirroring_i,
	output logic [mmc5_pkg::CHR_OUT_AW-1:0] chr_aout_o,
	output logic                            vram_a10_o,
	output logic                            vram_ce_o
);
	import mmc5_pkg::*;

	logic [9:0] chr_sel; // 1 kB page number
	logic [1:0] mirr_bits;

	always_comb begin
		case (chr_mode_i)
			CHR_8K: chr_sel = {chr_bank7_i[6:0], chr_addr_i[12:10]};
			CHR_4K: begin
				if (chr_addr_i[12])
					chr_sel = {chr_bank7_i, chr_addr_i[11:10]};
				else
					chr_sel = {chr_bank3_i, chr_addr_i[11:10]};
			end
			CHR_2K: begin
				case (chr_addr_i[12:11])
					2'd0:    chr_sel = {1'b0, chr_bank1_i, chr_addr_i[10]};
					2'd1:    chr_sel = {1'b0, chr_bank3_i, chr_addr_i[10]};
					2'd2:    chr_sel = {1'b0, chr_bank5_i, chr_addr_i[10]};
					default: chr_sel = {1'b0, chr_bank7_i, chr_addr_i[10]};
				endcase
			end
			default: begin
				case (chr_addr_i[12:10])
					3'd0:    chr_sel = {2'b00, chr_bank0_i};
					3'd1:    chr_sel = {2'b00, chr_bank1_i};
					3'd2:    chr_sel = {2'b00, chr_bank2_i};
					3'd3:    chr_sel = {2'b00, chr_bank3_i};
					3'd4:    chr_sel = {2'b00, chr_bank4_i};
					3'd5:    chr_sel = {2'b00, chr_bank5_i};
					3'd6:    chr_sel = {2'b00, chr_bank6_i};
					default: chr_sel = {2'b00, chr_bank7_i};
				endcase
			end
		endcase
	end

	assign chr_aout_o = {2'b10, chr_sel, chr_addr_i[9:0]}; // CHR ROM region

	// Two bits per quadrant, 0/1 pick VRAM page A/B, 2/3 leave VRAM off
	always_comb begin
		case (chr_addr_i[11:10])
			2'd0:    mirr_bits = mirroring_i[1:0];
			2'd1:    mirr_bits = mirroring_i[3:2];
			2'd2:    mirr_bits = mirroring_i[5:4];
			default: mirr_bits = mirroring_i[7:6];
		endcase
	end

	assign vram_a10_o = mirr_bits[0];
	assign vram_ce_o  = chr_addr_i[13] && !mirr_bits[1];

endmodule

/* hdl/mmc5_scanline.sv */
// MMC5 scanline detector, tracks in-frame state from PPU nametable reads and raises the line IRQ
`timescale 1ns/1ps

module mmc5_scanline (
	input  logic                            clk,
	input  logic                            rst_i,
	input  logic                            ce_i,
	input  logic [mmc5_pkg::PPU_AW-1:0]     chr_addr_i,
	input  logic                            chr_read_i,
	input  logic [mmc5_pkg::CPU_AW-1:0]     prg_addr_i,
	input  logic                            prg_read_i,
	input  logic [mmc5_pkg::SCANLINE_W-1:0] irq_line_i,
	input  logic                            irq_status_rd_i,
	output logic                            in_frame_o,
	output logic                            irq_pending_o
);
	import mmc5_pkg::*;

	logic                  last_chr_read;
	logic [11:0]           last_nt_addr;
	logic [1:0]            nt_cnt;   // Identical NT reads seen so far
	logic [1:0]            idle_cnt; // CPU cycles without a PPU read
	logic [SCANLINE_W-1:0] scanline;
	logic                  clr_req;  // Status was read, clear pending on next ce
	logic                  rd_edge;
	logic                  is_nt_addr;
	logic                  armed;
	logic                  line_end;
	logic                  idle_exit;
	logic                  nmi_exit;
	logic                  leave;

	assign rd_edge    = chr_read_i && !last_chr_read;
	assign is_nt_addr = (chr_addr_i[13:12] == 2'b10);
	assign armed      = (nt_cnt == NT_REPEAT);

	// Any of these drops the frame
	assign line_end  = rd_edge && armed && (scanline == LAST_SCANLINE);
	assign idle_exit = ce_i && !chr_read_i && (idle_cnt == IDLE_CE_LIMIT - 2'd1);
	assign nmi_exit  = ce_i && prg_read_i && ({prg_addr_i[CPU_AW-1:1], 1'b0} == NMI_VECTOR);
	assign leave     = in_frame_o && (line_end || idle_exit || nmi_exit);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			last_chr_read <= 1'b0;
			nt_cnt        <= '0;
			idle_cnt      <= '0;
			scanline      <= '0;
			clr_req       <= 1'b0;
			in_frame_o    <= 1'b0;
			irq_pending_o <= 1'b0;
		end else begin
			last_chr_read <= chr_read_i;

			// Status read clears pending one CPU cycle later
			if (irq_status_rd_i) begin
				clr_req <= 1'b1;
			end else if (ce_i && clr_req) begin
				clr_req       <= 1'b0;
				irq_pending_o <= 1'b0;
			end

			if (rd_edge) begin
				last_nt_addr <= chr_addr_i[11:0];
				if (!armed) begin
					nt_cnt <= nt_cnt + 2'd1;
				end else if (!in_frame_o) begin
					in_frame_o <= 1'b1;
					scanline   <= '0;
				end else if (scanline != LAST_SCANLINE) begin
					scanline <= scanline + 8'd1;
					if (scanline + 8'd1 == irq_line_i)
						irq_pending_o <= 1'b1;
				end
				// Restart the count on a non-NT read or a new NT address
				if (!is_nt_addr || (nt_cnt != 2'd0 && last_nt_addr != chr_addr_i[11:0]))
					nt_cnt <= '0;
			end

			if (ce_i) begin
				if (chr_read_i)
					idle_cnt <= '0;
				else if (in_frame_o)
					idle_cnt <= idle_cnt + 2'd1;
			end

			if (leave) begin
				in_frame_o    <= 1'b0;
				irq_pending_o <= 1'b0;
				nt_cnt        <= '0;
				idle_cnt      <= '0;
			end
		end
	end

endmodule

/* hdl/mmc5_top.sv */
// MMC5 mapper top level, joins the register file, PRG and CHR mappers and scanline detector
`timescale 1ns/1ps

module mmc5_top (
	input  logic                            clk,
	input  logic                            rst_i,
	input  logic                            ce_i,
	input  logic [mmc5_pkg::CPU_AW-1:0]     prg_addr_i,
	input  logic [7:0]                      prg_data_i,
	input  logic                            prg_write_i,
	input  logic                            prg_read_i,
	output logic [7:0]                      prg_dout_o,
	output logic                            prg_dout_valid_o,
	output logic [mmc5_pkg::PRG_OUT_AW-1:0] prg_aout_o,
	output logic                            prg_allow_o,
	input  logic [mmc5_pkg::PPU_AW-1:0]     chr_addr_i,
	input  logic                            chr_read_i,
	output logic [mmc5_pkg::CHR_OUT_AW-1:0] chr_aout_o,
	output logic                            vram_a10_o,
	output logic                            vram_ce_o,
	output logic                            irq_o
);
	import mmc5_pkg::*;

	prg_mode_e             prg_mode;
	chr_mode_e             chr_mode;
	logic [PRG_BANK_W-1:0] prg_bank0, prg_bank1, prg_bank2, prg_bank3;
	logic [RAM_BANK_W-1:0] ram_bank;
	logic                  ram_we;
	logic [CHR_BANK_W-1:0] chr_bank0, chr_bank1, chr_bank2, chr_bank3;
	logic [CHR_BANK_W-1:0] chr_bank4, chr_bank5, chr_bank6, chr_bank7;
	logic [MIRROR_W-1:0]   mirroring;
	logic [SCANLINE_W-1:0] irq_line;
	logic                  irq_status_rd;
	logic                  in_frame;
	logic                  irq_pending;

	mmc5_regs u_regs (
		.clk(clk), .rst_i(rst_i), .ce_i(ce_i),
		.prg_addr_i(prg_addr_i), .prg_data_i(prg_data_i),
		.prg_write_i(prg_write_i), .prg_read_i(prg_read_i),
		.in_frame_i(in_frame), .irq_pending_i(irq_pending),
		.prg_dout_o(prg_dout_o), .prg_dout_valid_o(prg_dout_valid_o),
		.prg_mode_o(prg_mode),
		.prg_bank0_o(prg_bank0), .prg_bank1_o(prg_bank1),
		.prg_bank2_o(prg_bank2), .prg_bank3_o(prg_bank3),
		.ram_bank_o(ram_bank), .ram_we_o(ram_we),
		.chr_mode_o(chr_mode),
		.chr_bank0_o(chr_bank0), .chr_bank1_o(chr_bank1),
		.chr_bank2_o(chr_bank2), .chr_bank3_o(chr_bank3),
		.chr_bank4_o(chr_bank4), .chr_bank5_o(chr_bank5),
		.chr_bank6_o(chr_bank6), .chr_bank7_o(chr_bank7),
		.mirroring_o(mirroring), .irq_line_o(irq_line),
		.irq_status_rd_o(irq_status_rd), .irq_o(irq_o)
	);

	mmc5_prg_map u_prg_map (
		.prg_addr_i(prg_addr_i), .prg_write_i(prg_write_i), .prg_mode_i(prg_mode),
		.prg_bank0_i(prg_bank0), .prg_bank1_i(prg_bank1),
		.prg_bank2_i(prg_bank2), .prg_bank3_i(prg_bank3),
		.ram_bank_i(ram_bank), .ram_we_i(ram_we),
		.prg_aout_o(prg_aout_o), .prg_allow_o(prg_allow_o)
	);

	mmc5_chr_map u_chr_map (
		.chr_addr_i(chr_addr_i), .chr_mode_i(chr_mode),
		.chr_bank0_i(chr_bank0), .chr_bank1_i(chr_bank1),
		.chr_bank2_i(chr_bank2), .chr_bank3_i(chr_bank3),
		.chr_bank4_i(chr_bank4), .chr_bank5_i(chr_bank5),
		.chr_bank6_i(chr_bank6), .chr_bank7_i(chr_bank7),
		.mirroring_i(mirroring),
		.chr_aout_o(chr_aout_o), .vram_a10_o(vram_a10_o), .vram_ce_o(vram_ce_o)
	);

	mmc5_scanline u_scanline (
		.clk(clk), .rst_i(rst_i), .ce_i(ce_i),
		.chr_addr_i(chr_addr_i), .chr_read_i(chr_read_i),
		.prg_addr_i(prg_addr_i), .prg_read_i(prg_read_i),
		.irq_line_i(irq_line), .irq_status_rd_i(irq_status_rd),
		.in_frame_o(in_frame), .irq_pending_o(irq_pending)
	);

endmodule

/* verif/mmc5_chk.sv */
// MMC5 assertion checker, bound to the mapper top level to watch reset state and output relations
`timescale 1ns/1ps

module mmc5_chk (
	input logic                        clk,
	input logic                        rst_i,
	input logic                        irq_o,
	input logic                        in_frame,
	input logic                        irq_pending,
	input logic [mmc5_pkg::CPU_AW-1:0] prg_addr_i,
	input logic                        prg_allow_o,
	input logic [mmc5_pkg::PPU_AW-1:0] chr_addr_i,
	input logic                        vram_ce_o
);
	import mmc5_pkg::*;

	a_reset_idle: assert property (@(posedge clk) rst_i |=> (!irq_o && !in_frame && !irq_pending))
		else $error("IRQ or frame state not clear after reset");

	// Nothing below PRG RAM is served
	a_prg_floor: assert property (@(posedge clk) disable iff (rst_i)
		(prg_addr_i < PRG_RAM_BASE) |-> !prg_allow_o)
		else $error("PRG access allowed below the RAM base");

	a_vram_nt: assert property (@(posedge clk) disable iff (rst_i)
		$rose(vram_ce_o) |-> chr_addr_i[13])
		else $error("VRAM enabled outside nametable space");

endmodule

bind mmc5_top mmc5_chk u_chk (
	.clk(clk), .rst_i(rst_i), .irq_o(irq_o),
	.in_frame(in_frame), .irq_pending(irq_pending),
	.prg_addr_i(prg_addr_i), .prg_allow_o(prg_allow_o),
	.chr_addr_i(chr_addr_i), .vram_ce_o(vram_ce_o)
);

/* verif/mmc5_tb.sv */
// Self-checking MMC5 mapper testbench that drives random register, CPU and PPU traffic against a model
`timescale 1ns/1ps

module mmc5_tb;
	import mmc5_pkg::*;

	// Longest run is about 7000 cycles for two full frames plus the banking loops
	localparam int MAX_CYCLES = 20000;

	logic                  clk;
	logic                  rst_i;
	logic                  ce_i;
	logic [CPU_AW-1:0]     prg_addr_i;
	logic [7:0]            prg_data_i;
	logic                  prg_write_i;
	logic                  prg_read_i;
	logic [7:0]            prg_dout_o;
	logic                  prg_dout_valid_o;
	logic [PRG_OUT_AW-1:0] prg_aout_o;
	logic                  prg_allow_o;
	logic [PPU_AW-1:0]     chr_addr_i;
	logic                  chr_read_i;
	logic [CHR_OUT_AW-1:0] chr_aout_o;
	logic                  vram_a10_o;
	logic                  vram_ce_o;
	logic                  irq_o;

	integer     seed;
	int         cycles;
	int         ce_phase;
	logic [7:0] rd_data;  // Read data captured in the ce cycle
	logic       rd_valid;

	// Register model
	prg_mode_e  m_prg_mode;
	chr_mode_e  m_chr_mode;
	logic [7:0] m_prg_bank [4];
	logic [7:0] m_chr_bank [8];
	logic [2:0] m_ram_bank;
	logic       m_p1;
	logic       m_p2;
	logic [7:0] m_mirr;
	logic [7:0] m_irq_line;

	// Scanline model
	int         m_nt_cnt;
	logic [11:0] m_last_nt;
	logic       m_in_frame;
	int         m_line;
	logic       m_pending;

	mmc5_top u_mmc5_top (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// CPU clock enable high one clock in three
	initial begin
		ce_i     = 1'b0;
		ce_phase = 0;
		forever begin
			@(posedge clk);
			#2;
			ce_i     = (ce_phase == 2);
			ce_phase = (ce_phase + 1) % 3;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Run did not finish within %0d cycles", MAX_CYCLES);
			$display("Testbench failed");
			$fatal(1, "Timeout");
		end
	end

	task automatic stop_run(string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "Check failed");
	endtask

	task automatic check_addr(string name, logic [21:0] got, logic [21:0] exp);
		if (got !== exp)
			stop_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
			stop_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
		if (got !== exp)
			stop_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_prg_mode(string name, prg_mode_e got, prg_mode_e exp);
		if (got !== exp)
			stop_run($sformatf("** Error at %0t: %s is %s, expected %s", $time, name,
				got.name(), exp.name()));
	endtask

	task automatic check_chr_mode(string name, chr_mode_e got, chr_mode_e exp);
		if (got !== exp)
			stop_run($sformatf("** Error at %0t: %s is %s, expected %s", $time, name,
				got.name(), exp.name()));
	endtask

	// Runs from 2 ns after an edge through the next ce edge and captures read data on the way
	task automatic pass_ce;
		#18;
		while (!ce_i) begin
			@(posedge clk);
			#20;
		end
		rd_data  = prg_dout_o;
		rd_valid = prg_dout_valid_o;
		@(posedge clk);
		#2;
	endtask

	task automatic set_reg(logic [15:0] addr, logic [7:0] data);
		prg_addr_i  = addr;
		prg_data_i  = data;
		prg_write_i = 1'b1;
		pass_ce();
		prg_write_i = 1'b0;
		case (addr)
			REG_PRG_MODE:     m_prg_mode = prg_mode_e'(data[1:0]);
			REG_CHR_MODE:     m_chr_mode = chr_mode_e'(data[1:0]);
			REG_PROT1:        m_p1 = (data[1:0] == PROT1_KEY);
			REG_PROT2:        m_p2 = (data[1:0] == PROT2_KEY);
			REG_MIRROR:       m_mirr = data;
			REG_PRG_RAM_BANK: m_ram_bank = data[2:0];
			REG_IRQ_LINE:     m_irq_line = data;
			default: begin
				if (addr >= REG_PRG_BANK0 && addr <= REG_PRG_BANK3)
					m_prg_bank[2'(addr - REG_PRG_BANK0)] = data;
				else if (addr[15:3] == REG_CHR_BANK0[15:3])
					m_chr_bank[addr[2:0]] = data;
			end
		endcase
	endtask

	task automatic cpu_read(logic [15:0] addr);
		prg_addr_i = addr;
		prg_read_i = 1'b1;
		pass_ce();
		prg_read_i = 1'b0;
	endtask

	// Status read after which pending is gone one CPU cycle later
	task automatic check_status;
		cpu_read(REG_IRQ_STATUS);
		check_byte("status $5204", rd_data, {m_pending, m_in_frame, 6'h3F});
		pass_ce();
		m_pending = 1'b0;
	endtask

	task automatic leave_frame;
		m_in_frame = 1'b0;
		m_pending  = 1'b0;
		m_nt_cnt   = 0;
	endtask

	// One PPU read edge that leaves chr_read_i high
	task automatic ppu_read(logic [13:0] addr);
		int prev;
		prev       = m_nt_cnt;
		chr_read_i = 1'b0;
		@(posedge clk);
		#2;
		chr_addr_i = addr;
		chr_read_i = 1'b1;
		@(posedge clk);
		#2;
		if (m_nt_cnt < 3)
			m_nt_cnt++;
		else if (!m_in_frame) begin
			m_in_frame = 1'b1;
			m_line     = 0;
		end else if (m_line == int'(LAST_SCANLINE))
			leave_frame();
		else begin
			m_line++;
			if (m_line == int'(m_irq_line))
				m_pending = 1'b1;
		end
		if (addr[13:12] != 2'b10 || (prev != 0 && m_last_nt != addr[11:0]))
			m_nt_cnt = 0;
		m_last_nt = addr[11:0];
	endtask

	// Three identical nametable reads and then a pattern fetch
	task automatic run_line(logic [13:0] nt);
		repeat (3) ppu_read(nt);
		ppu_read(14'h0040);
	endtask

	task automatic prg_probe(logic [15:0] a, logic wr);
		logic [7:0]  sel;
		logic [21:0] exp;
		if (!a[15])
			sel = {5'd0, m_ram_bank};
		else begin
			case (m_prg_mode)
				PRG_32K: sel = 8'h80 | ((m_prg_bank[3] & 8'h7C) + 8'(a[14:13]));
				PRG_16K: sel = a[14] ? (8'h80 | ((m_prg_bank[3] & 8'h7E) + 8'(a[13])))
				                     : ((m_prg_bank[1] & 8'hFE) + 8'(a[13]));
				PRG_16K_8K: begin
					if (!a[14])
						sel = (m_prg_bank[1] & 8'hFE) + 8'(a[13]);
					else
						sel = a[13] ? (8'h80 | m_prg_bank[3]) : m_prg_bank[2];
				end
				default: sel = (a[14:13] == 2'd3) ? (8'h80 | m_prg_bank[3]) : m_prg_bank[a[14:13]];
			endcase
		end
		exp = sel[7] ? {2'b00, sel[6:0], a[12:0]} : {PRG_RAM_PAGE, sel[2:0], a[12:0]};
		prg_addr_i  = a;
		prg_write_i = wr;
		#18;
		if (a >= PRG_RAM_BASE)
			check_addr("prg_aout_o", prg_aout_o, exp);
		check_bit("prg_allow_o", prg_allow_o,
			(a >= PRG_RAM_BASE) && (!wr || (!sel[7] && m_p1 && m_p2)));
		@(posedge clk);
		#2;
		prg_write_i = 1'b0;
	endtask

	task automatic chr_probe(logic [13:0] a);
		logic [9:0] page;
		logic [7:0] bits;
		case (m_chr_mode)
			CHR_8K:  page = 10'(m_chr_bank[7]) * 10'd8 + 10'(a[12:10]);
			CHR_4K:  page = 10'(m_chr_bank[a[12] ? 7 : 3]) * 10'd4 + 10'(a[11:10]);
			CHR_2K:  page = 10'(m_chr_bank[{a[12:11], 1'b1}]) * 10'd2 + 10'(a[10]);
			default: page = 10'(m_chr_bank[a[12:10]]);
		endcase
		bits       = m_mirr >> (2 * a[11:10]);
		chr_addr_i = a;
		#18;
		check_addr("chr_aout_o", chr_aout_o, {2'b10, page, a[9:0]});
		check_bit("vram_a10_o", vram_a10_o, bits[0]);
		check_bit("vram_ce_o", vram_ce_o, a[13] && !bits[1]);
		@(posedge clk);
		#2;
	endtask

	initial begin
		logic [31:0] r;
		logic [15:0] a;
		logic [13:0] nt;
		logic [7:0]  ma;
		logic [7:0]  mb;
		logic [15:0] prod;
		int          n;
		seed        = 32'hb8b3;
		cycles      = 0;
		rst_i       = 1'b1;
		prg_addr_i  = '0;
		prg_data_i  = '0;
		prg_write_i = 1'b0;
		prg_read_i  = 1'b0;
		chr_addr_i  = '0;
		chr_read_i  = 1'b0;
		m_prg_mode  = PRG_8K;
		m_chr_mode  = CHR_8K;
		m_prg_bank  = '{8'h00, 8'h00, 8'h00, 8'h7F};
		m_chr_bank  = '{default: 8'h00};
		m_ram_bank  = '0;
		m_p1        = 1'b0;
		m_p2        = 1'b0;
		m_mirr      = '0;
		m_irq_line  = '0;
		m_nt_cnt    = 0;
		m_last_nt   = '0;
		m_in_frame  = 1'b0;
		m_line      = 0;
		m_pending   = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rst_i = 1'b0;

		// Reset state maps the top window to ROM page $7F
		check_prg_mode("prg_mode", u_mmc5_top.prg_mode, PRG_8K);
		check_chr_mode("chr_mode", u_mmc5_top.chr_mode, CHR_8K);
		repeat (16) begin
			r = $random(seed);
			prg_probe(16'hE000 | (r[15:0] & 16'h1FFF), 1'b0);
			check_bit("irq_o", irq_o, 1'b0);
		end

		repeat (40) begin
			set_reg(REG_PRG_MODE, 8'($random(seed)));
			for (int i = 0; i < 4; i++)
				set_reg(REG_PRG_BANK0 + 16'(i), 8'($random(seed)));
			set_reg(REG_PRG_RAM_BANK, 8'($random(seed)));
			r = $random(seed);
			set_reg(REG_PROT1, r[0] ? 8'(PROT1_KEY) : r[15:8]);
			set_reg(REG_PROT2, r[1] ? 8'(PROT2_KEY) : r[23:16]);
			check_prg_mode("prg_mode", u_mmc5_top.prg_mode, m_prg_mode);
			repeat (6) begin
				r = $random(seed);
				a = r[15:0];
				if (a[15:12] == 4'h5)
					a = a ^ 16'h8000; // Keep writes off the register page
				prg_probe(a, r[16]);
			end
		end

		repeat (40) begin
			set_reg(REG_CHR_MODE, 8'($random(seed)));
			for (int i = 0; i < 8; i++)
				set_reg(REG_CHR_BANK0 + 16'(i), 8'($random(seed)));
			set_reg(REG_MIRROR, 8'($random(seed)));
			check_chr_mode("chr_mode", u_mmc5_top.chr_mode, m_chr_mode);
			repeat (8) chr_probe(14'($random(seed)));
		end

		// Multiplier
		repeat (20) begin
			ma   = 8'($random(seed));
			mb   = 8'($random(seed));
			prod = 16'(ma) * 16'(mb);
			set_reg(REG_MUL_A, ma);
			set_reg(REG_MUL_B, mb);
			cpu_read(REG_MUL_A);
			check_byte("product low", rd_data, prod[7:0]);
			check_bit("prg_dout_valid_o", rd_valid, 1'b1);
			cpu_read(REG_MUL_B);
			check_byte("product high", rd_data, prod[15:8]);
			a = 16'($random(seed));
			if (a >= REG_IRQ_STATUS && a <= REG_MUL_B)
				a = 16'h4000;
			prg_addr_i = a;
			#18;
			check_bit("prg_dout_valid_o", prg_dout_valid_o, 1'b0);
			@(posedge clk);
			#2;
		end

		// Scanline IRQ on a random line
		r  = $random(seed);
		nt = {2'b10, r[11:0]};
		set_reg(REG_IRQ_LINE, 8'(1 + (r[31:16] % 200)));
		set_reg(REG_IRQ_STATUS, 8'h80);
		for (int k = 0; k <= int'(m_irq_line); k++) begin
			run_line(nt);
			if (k < int'(m_irq_line))
				check_bit("irq_o", irq_o, 1'b0);
		end
		n = 0;
		while (!irq_o) begin
			if (n == 8)
				stop_run("irq_o did not rise after the compare line");
			@(posedge clk);
			#2;
			n++;
		end
		check_status();
		check_status();

		// NMI vector fetch
		cpu_read(NMI_VECTOR);
		leave_frame();
		check_status();

		// PPU goes quiet
		run_line(nt);
		check_status();
		chr_read_i = 1'b0;
		repeat (4) pass_ce();
		leave_frame();
		check_status();

		// Past the last visible line
		repeat (240) run_line(nt);
		check_status();
		run_line(nt);
		check_status();
		check_bit("status bit 6 after line 239", rd_data[6], 1'b0);

		$display("Testbench passed");
		$finish;
	end

endmodule

/* verilog.f */
hdl/mmc5_pkg.sv
hdl/mmc5_regs.sv
hdl/mmc5_prg_map.sv
hdl/mmc5_chr_map.sv
hdl/mmc5_scanline.sv
hdl/mmc5_top.sv
verif/mmc5_chk.sv
verif/mmc5_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the MMC5 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module mmc5_tb -f verilog.f -o Vmmc5_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./obj_dir/Vmmc5_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation returned status $status"
	exit $status
fi

exit 0
